//--- src.f
+incdir+hw
hw/corr_pkg.sv
hw/corr_sample_timer.sv
hw/corr_count_rect.sv
hw/corr_count_logdrop.sv
hw/corr_packetizer.sv
hw/corr_pkt_fifo.sv
hw/correlator.sv
dv/tb_clkgen.sv
dv/tb_correlator.sv

//--- dv/tb_correlator.sv
`timescale 1ns/1ps
`include "corr_config.svh"

module tb_correlator;

  localparam int NUM_ROWS = 12;
  localparam int DEPTH    = `CORR_FIFO_DEPTH;
  localparam int PREC     = `CORR_PRECISION;
  localparam int LMAX     = `CORR_MAX_WINDOW_EXP;
  localparam int DRAIN    = 12; // Clocks after the last full window of a row.

  localparam logic [1:0] PAT_ZERO  = 2'd0;
  localparam logic [1:0] PAT_ONE   = 2'd1;
  localparam logic [1:0] PAT_ALT   = 2'd2;
  localparam logic [1:0] PAT_RAND  = 2'd3;
  localparam logic [1:0] RDY_ON    = 2'd0;
  localparam logic [1:0] RDY_RAND  = 2'd1;
  localparam logic [1:0] RDY_STALL = 2'd2;

  typedef struct packed {
    corr_pkg::corr_cfg_t cfg;
    logic [1:0]          pat;
    logic [7:0]          windows;
    logic [1:0]          rdy;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  x;
  logic                  y;
  corr_pkg::corr_cfg_t   cfg;
  logic                  cfg_load;
  logic                  pkt_ready;
  corr_pkg::corr_byte_t  pkt_data;
  logic                  pkt_valid;

  row_t                  rows [NUM_ROWS];
  integer                seed;
  int                    errors;
  int                    bytes_seen;
  logic [15:0]           row_cyc;
  logic [15:0]           glob_cyc;
  logic [1:0]            cur_pat;
  logic [1:0]            cur_rdy;
  int                    cur_pexp;

  // Reference model state, stepped once per clock edge.
  int                    m_l;
  int                    m_p;
  corr_pkg::corr_shape_e m_shape;
  int                    m_presc;
  int                    m_t;
  int                    m_win;
  int                    m_due; // Clocks until the selected report is valid.
  logic                  m_busy;
  int                    m_idx;
  int                    m_cnt [4];
  int                    m_acc [4];
  logic [7:0]            m_rep [5];
  logic [7:0]            m_pkt [5];
  logic [7:0]            exp_q [$];

  tb_clkgen u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  correlator u_correlator (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_x         (x),
    .i_y         (y),
    .i_cfg       (cfg),
    .i_cfg_load  (cfg_load),
    .o_pkt_data  (pkt_data),
    .o_pkt_valid (pkt_valid),
    .i_pkt_ready (pkt_ready)
  );

  function automatic row_t make_row(input int l, input corr_pkg::corr_shape_e s,
                                    input int p, input logic [1:0] pat,
                                    input int wins, input logic [1:0] rdy);
    row_t r;
    r.cfg.window_exp = 4'(l);
    r.cfg.shape      = s;
    r.cfg.period_exp = 3'(p);
    r.pat            = pat;
    r.windows        = 8'(wins);
    r.rdy            = rdy;
    return r;
  endfunction

  function automatic int row_clocks(input row_t r);
    return 1 + int'(r.windows) * (1 << (int'(r.cfg.window_exp) + int'(r.cfg.period_exp)))
           + DRAIN;
  endfunction

  function automatic logic [7:0] rect_byte(input int cnt, input int l);
    int v;
    v = (cnt * 256) >> l;
    return (v > 255) ? 8'hff : 8'(v);
  endfunction

  function automatic logic [7:0] logdrop_byte(input int acc, input int l);
    int v;
    v = acc >> (PREC + l - 7);
    return (v > 255) ? 8'hff : 8'(v);
  endfunction

  function automatic int msb_index(input int v);
    int k;
    k = 0;
    for (int b = 0; b < 31; b++) begin
      if (v[b]) begin
        k = b;
      end
    end
    return k;
  endfunction

  task automatic set_inputs();
    case (cur_pat)
      PAT_ZERO: begin
        x = 1'b0;
        y = 1'b0;
      end
      PAT_ONE: begin
        x = 1'b1;
        y = 1'b1;
      end
      PAT_ALT: begin
        x = row_cyc[cur_pexp]; // Flips on every sample.
        y = row_cyc[cur_pexp + 1];
      end
      default: begin
        x = 1'($random(seed));
        y = 1'($random(seed));
      end
    endcase
    case (cur_rdy)
      RDY_ON:   pkt_ready = 1'b1;
      RDY_RAND: pkt_ready = 1'($random(seed));
      default:  pkt_ready = &glob_cyc[6:3]; // High for 8 clocks out of 128.
    endcase
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;
    row_cyc  = row_cyc + 1'b1;
    glob_cyc = glob_cyc + 1'b1;
  endtask

  task automatic check_outputs();
    if (pkt_valid !== (exp_q.size() != 0)) begin
      $display("MISMATCH at %0t: o_pkt_valid expected %0b, got %0b",
               $time, exp_q.size() != 0, pkt_valid);
      errors++;
    end else if (pkt_valid && pkt_ready) begin
      bytes_seen++;
      if (pkt_data !== exp_q[0]) begin
        $display("MISMATCH at %0t: byte %0d expected 0x%02h, got 0x%02h",
                 $time, bytes_seen, exp_q[0], pkt_data);
        errors++;
      end
    end
  endtask

  // Works out what the coming rising edge does from the inputs now held.
  task automatic step_model();
    logic       strobe;
    logic       wrap;
    logic       accept;
    logic [3:0] ev;
    logic [7:0] dummy;
    int         w;
    strobe = (m_presc == (1 << m_p) - 1) && !cfg_load;
    wrap   = strobe && (m_t == (1 << m_l) - 1);
    accept = (m_due == 1) && !m_busy && (DEPTH - exp_q.size() >= 5) && !cfg_load;

    if (cfg_load) begin
      exp_q.delete();
    end else begin
      if (pkt_ready && exp_q.size() != 0) begin
        dummy = exp_q.pop_front();
      end
      if (m_busy) begin
        exp_q.push_back(m_pkt[m_idx]);
      end
    end

    if (cfg_load) begin
      m_busy = 1'b0;
      m_idx  = 0;
    end else if (accept) begin
      m_busy = 1'b1;
      m_idx  = 0;
      for (int i = 0; i < 5; i++) begin
        m_pkt[i] = m_rep[i];
      end
    end else if (m_busy) begin
      m_busy = (m_idx != 4);
      m_idx  = (m_idx == 4) ? 0 : m_idx + 1;
    end

    if (m_due > 0) begin
      m_due--;
    end
    if (cfg_load) begin
      m_l     = (int'(cfg.window_exp) > LMAX) ? LMAX : int'(cfg.window_exp);
      m_p     = int'(cfg.period_exp);
      m_shape = cfg.shape;
      m_presc = 0;
      m_t     = 0;
      m_due   = 0;
      for (int i = 0; i < 4; i++) begin
        m_cnt[i] = 0;
        m_acc[i] = 0;
      end
    end else if (strobe) begin
      ev = {x ^ y, x & y, y, x};
      w  = 1 << (PREC - m_l + msb_index(m_t + 1));
      for (int i = 0; i < 4; i++) begin
        if (ev[i]) begin
          m_cnt[i] += 1;
          m_acc[i] += w;
        end
      end
      if (wrap) begin
        m_rep[0] = 8'(m_win);
        for (int i = 0; i < 4; i++) begin
          m_rep[i + 1] = (m_shape == corr_pkg::SHAPE_RECT) ? rect_byte(m_cnt[i], m_l)
                                                            : logdrop_byte(m_acc[i], m_l);
          m_cnt[i] = 0;
          m_acc[i] = 0;
        end
        m_due = (m_shape == corr_pkg::SHAPE_RECT) ? 1 : 2;
        m_win = (m_win + 1) % 256;
        m_t   = 0;
      end else begin
        m_t++;
      end
      m_presc = 0;
    end else begin
      m_presc++;
    end
  endtask

  // Outputs and the inputs driven 5 ns after the edge are all settled here.
  always @(negedge clk) begin
    if (rst_n) begin
      check_outputs();
      step_model();
    end
  end

  initial begin
    seed       = 26;
    errors     = 0;
    bytes_seen = 0;
    x          = 1'b0;
    y          = 1'b0;
    cfg        = '0;
    cfg_load   = 1'b0;
    pkt_ready  = 1'b1;
    row_cyc    = '0;
    glob_cyc   = '0;
    cur_pat    = PAT_ZERO;
    cur_rdy    = RDY_ON;
    cur_pexp   = 0;
    m_l        = 0;
    m_p        = 0;
    m_shape    = corr_pkg::SHAPE_RECT;
    m_presc    = 0;
    m_t        = 0;
    m_win      = 0;
    m_due      = 0;
    m_busy     = 1'b0;
    m_idx      = 0;

    rows[0]  = make_row(3, corr_pkg::SHAPE_RECT, 0, PAT_ALT, 6, RDY_ON);
    rows[1]  = make_row(4, corr_pkg::SHAPE_RECT, 2, PAT_RAND, 4, RDY_ON);
    rows[2]  = make_row(6, corr_pkg::SHAPE_RECT, 1, PAT_RAND, 3, RDY_RAND);
    rows[3]  = make_row(8, corr_pkg::SHAPE_RECT, 0, PAT_ONE, 2, RDY_ON);
    rows[4]  = make_row(3, corr_pkg::SHAPE_LOGDROP, 0, PAT_ALT, 6, RDY_ON);
    rows[5]  = make_row(5, corr_pkg::SHAPE_LOGDROP, 1, PAT_RAND, 4, RDY_ON);
    rows[6]  = make_row(8, corr_pkg::SHAPE_LOGDROP, 0, PAT_ONE, 2, RDY_RAND);
    rows[7]  = make_row(2, corr_pkg::SHAPE_LOGDROP, 3, PAT_ZERO, 5, RDY_ON);
    rows[8]  = make_row(1, corr_pkg::SHAPE_RECT, 0, PAT_RAND, 60, RDY_STALL);
    rows[9]  = make_row(2, corr_pkg::SHAPE_LOGDROP, 1, PAT_RAND, 40, RDY_STALL);
    rows[10] = make_row(4, corr_pkg::SHAPE_RECT, 7, PAT_ALT, 2, RDY_ON);
    rows[11] = make_row(3, corr_pkg::SHAPE_LOGDROP, 2, PAT_ALT, 3, RDY_ON);

    wait (rst_n === 1'b1);
    for (int r = 0; r < NUM_ROWS; r++) begin
      cfg      = rows[r].cfg;
      cur_pat  = rows[r].pat;
      cur_rdy  = rows[r].rdy;
      cur_pexp = int'(rows[r].cfg.period_exp);
      row_cyc  = '0;
      cfg_load = 1'b1; // Each row starts part way into the previous row's window.
      set_inputs();
      next_cycle();
      cfg_load = 1'b0;
      repeat (row_clocks(rows[r]) - 1) begin
        set_inputs();
        next_cycle();
      end
    end

    if (exp_q.size() != 0) begin
      $display("%0d expected bytes were never delivered", exp_q.size());
      errors++;
    end
    if (bytes_seen == 0) begin
      $display("No packet bytes were received from the DUT");
      errors++;
    end
    $display("errors=%0d bytes=%0d", errors, bytes_seen);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    int total;
    wait (rst_n === 1'b1);
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += row_clocks(rows[r]);
    end
    #(total * 2 * 100 + 10000);
    $display("Watchdog timeout: the table did not finish within %0d clocks", total * 2 + 100);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk; // 100 ns period.
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (8) @(posedge o_clk);
    #5 o_rst_n = 1'b1; // Released with the same skew as the other inputs.
  end

endmodule

//--- hw/correlator.sv
`timescale 1ns/1ps
`include "corr_config.svh"

module correlator (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_x,
  input  logic                 i_y,
  input  corr_pkg::corr_cfg_t  i_cfg,
  input  logic                 i_cfg_load,
  output corr_pkg::corr_byte_t o_pkt_data,
  output logic                 o_pkt_valid,
  input  logic                 i_pkt_ready
);

  corr_pkg::corr_sample_t                       sample;
  logic                                         strobe;
  logic [`CORR_MAX_WINDOW_EXP-1:0]              t;
  logic                                         wrap;
  corr_pkg::corr_report_t                       rect_report;
  logic                                         rect_valid;
  corr_pkg::corr_report_t                       logdrop_report;
  logic                                         logdrop_valid;
  logic                                         fifo_push;
  logic                                         fifo_flush;
  logic                                         fifo_pop;
  corr_pkg::corr_byte_t                         fifo_data;
  logic [$clog2(`CORR_FIFO_DEPTH+1)-1:0]       fifo_free;

  assign sample   = '{x: i_x, y: i_y};
  assign fifo_pop = o_pkt_valid & i_pkt_ready; // A byte leaves on the handshake.

  corr_sample_timer u_timer (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cfg      (i_cfg),
    .i_cfg_load (i_cfg_load),
    .o_strobe   (strobe),
    .o_t        (t),
    .o_wrap     (wrap)
  );

  // Both counters take the window exponent on the load pulse.
  corr_count_rect u_rect (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_sample       (sample),
    .i_strobe       (strobe),
    .i_wrap         (wrap),
    .i_window_exp   (i_cfg.window_exp),
    .i_clear        (i_cfg_load),
    .o_report       (rect_report),
    .o_report_valid (rect_valid)
  );

  corr_count_logdrop u_logdrop (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_sample       (sample),
    .i_strobe       (strobe),
    .i_wrap         (wrap),
    .i_t            (t),
    .i_window_exp   (i_cfg.window_exp),
    .i_clear        (i_cfg_load),
    .o_report       (logdrop_report),
    .o_report_valid (logdrop_valid)
  );

  corr_packetizer u_packetizer (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_cfg            (i_cfg),
    .i_cfg_load       (i_cfg_load),
    .i_wrap           (wrap),
    .i_rect_report    (rect_report),
    .i_rect_valid     (rect_valid),
    .i_logdrop_report (logdrop_report),
    .i_logdrop_valid  (logdrop_valid),
    .i_fifo_free      (fifo_free),
    .o_push           (fifo_push),
    .o_data           (fifo_data),
    .o_flush          (fifo_flush)
  );

  corr_pkt_fifo u_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_flush (fifo_flush),
    .i_push  (fifo_push),
    .i_data  (fifo_data),
    .i_pop   (fifo_pop),
    .o_data  (o_pkt_data),
    .o_valid (o_pkt_valid),
    .o_free  (fifo_free)
  );

endmodule

//--- hw/corr_pkt_fifo.sv
`timescale 1ns/1ps
`include "corr_config.svh"

module corr_pkt_fifo (
  input  logic                                   i_clk,
  input  logic                                   i_rst_n,
  input  logic                                   i_flush,
  input  logic                                   i_push,
  input  corr_pkg::corr_byte_t                   i_data,
  input  logic                                   i_pop,
  output corr_pkg::corr_byte_t                   o_data,
  output logic                                   o_valid,
  output logic [$clog2(`CORR_FIFO_DEPTH+1)-1:0] o_free
);

  localparam int DEPTH  = `CORR_FIFO_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int FREE_W = $clog2(DEPTH + 1);

  corr_pkg::corr_byte_t mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [FREE_W-1:0]    free_q;
  logic                 do_push;
  logic                 do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign o_valid = (free_q != FREE_W'(DEPTH));
  assign o_free  = free_q;
  assign o_data  = mem[rd_ptr_q]; // Stable until popped.

  assign do_push = i_push && (free_q != '0);
  assign do_pop  = i_pop && o_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      free_q   <= FREE_W'(DEPTH);
    end else if (i_flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      free_q   <= FREE_W'(DEPTH);
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      free_q <= free_q - FREE_W'(do_push) + FREE_W'(do_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= i_data;
    end
  end

endmodule

//--- hw/corr_packetizer.sv
`timescale 1ns/1ps
`include "corr_config.svh"

module corr_packetizer (
  input  logic                                   i_clk,
  input  logic                                   i_rst_n,
  input  corr_pkg::corr_cfg_t                    i_cfg,
  input  logic                                   i_cfg_load,
  input  logic                                   i_wrap,
  input  corr_pkg::corr_report_t                 i_rect_report,
  input  logic                                   i_rect_valid,
  input  corr_pkg::corr_report_t                 i_logdrop_report,
  input  logic                                   i_logdrop_valid,
  input  logic [$clog2(`CORR_FIFO_DEPTH+1)-1:0] i_fifo_free,
  output logic                                   o_push,
  output corr_pkg::corr_byte_t                   o_data,
  output logic                                   o_flush
);

  localparam int PKT_LEN = 5;

  corr_pkg::corr_shape_e  shape_q;
  logic [7:0]             win_q;
  logic [1:0][7:0]        tag_q;
  logic                   is_logdrop;
  corr_pkg::corr_report_t sel_report;
  logic                   sel_valid;
  logic [7:0]             sel_tag;
  logic                   busy_q;
  logic [2:0]             byte_idx_q;
  logic                   accept;
  corr_pkg::corr_byte_t   pkt_q [PKT_LEN];

  assign is_logdrop = (shape_q == corr_pkg::SHAPE_LOGDROP);
  assign sel_report = is_logdrop ? i_logdrop_report : i_rect_report;
  assign sel_valid  = is_logdrop ? i_logdrop_valid : i_rect_valid;
  // The logdrop report trails the wrap by one clock more than the rect one.
  assign sel_tag    = is_logdrop ? tag_q[1] : tag_q[0];

  // A whole packet is taken or the report is dropped.
  assign accept = sel_valid && !busy_q && (i_fifo_free >= PKT_LEN) && !i_cfg_load;

  assign o_push  = busy_q;
  assign o_data  = pkt_q[byte_idx_q];
  assign o_flush = i_cfg_load;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      shape_q    <= corr_pkg::SHAPE_RECT;
      win_q      <= '0;
      busy_q     <= 1'b0;
      byte_idx_q <= '0;
    end else begin
      if (i_cfg_load) begin
        shape_q <= i_cfg.shape;
      end
      if (i_wrap) begin
        win_q <= win_q + 1'b1; // Kept across loads.
      end
      if (i_cfg_load) begin
        busy_q     <= 1'b0;
        byte_idx_q <= '0;
      end else if (accept) begin
        busy_q     <= 1'b1;
        byte_idx_q <= '0;
      end else if (busy_q) begin
        busy_q     <= (byte_idx_q != 3'(PKT_LEN - 1));
        byte_idx_q <= (byte_idx_q == 3'(PKT_LEN - 1)) ? '0 : byte_idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    tag_q <= {tag_q[0], win_q};
    if (accept) begin
      pkt_q[0] <= sel_tag;
      pkt_q[1] <= sel_report.cnt_x;
      pkt_q[2] <= sel_report.cnt_y;
      pkt_q[3] <= sel_report.cnt_isect;
      pkt_q[4] <= sel_report.cnt_symdiff;
    end
  end

  // The free-space check at accept covers all five bytes of the packet.
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_push |-> (i_fifo_free != '0));

endmodule

//--- hw/corr_count_logdrop.sv
`timescale 1ns/1ps
`include "corr_config.svh"

module corr_count_logdrop (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  corr_pkg::corr_sample_t          i_sample,
  input  logic                            i_strobe,
  input  logic                            i_wrap,
  input  logic [`CORR_MAX_WINDOW_EXP-1:0] i_t,
  input  logic [3:0]                      i_window_exp,
  input  logic                            i_clear,
  output corr_pkg::corr_report_t          o_report,
  output logic                            o_report_valid
);

  localparam int         TW    = `CORR_MAX_WINDOW_EXP;
  localparam int         AW    = `CORR_ACC_W;
  localparam logic [3:0] L_MAX = 4'(TW);

  logic [3:0]             l_q;
  logic [TW:0]            t_inc;
  logic [4:0]             w_exp;
  logic [4:0]             shift;
  corr_pkg::corr_sample_t samp_q;
  logic [AW-1:0]          weight_q;
  logic                   stb_q;
  logic                   wrap_q;
  logic [3:0]             ev;
  logic [AW-1:0]          acc_q [4];
  logic [AW:0]            acc_sum [4];
  logic [3:0]             carry;
  logic [3:0][7:0]        rep_q;
  logic                   valid_q;

  function automatic logic [3:0] top_bit(input logic [TW:0] v);
    logic [3:0] k;
    k = '0;
    for (int b = 0; b <= TW; b++) begin
      if (v[b]) begin
        k = 4'(b);
      end
    end
    return k;
  endfunction

  function automatic logic [7:0] scale(input logic [AW-1:0] acc, input logic [4:0] sh);
    logic [AW-1:0] full;
    full = acc >> sh;
    return (|full[AW-1:8]) ? 8'hff : full[7:0];
  endfunction

  // Weight exponent is PRECISION - L + k, with k the top set bit of t+1.
  assign t_inc = {1'b0, i_t} + 1'b1;
  assign w_exp = 5'(`CORR_PRECISION) - 5'(l_q) + 5'(top_bit(t_inc));
  assign shift = 5'(`CORR_PRECISION) + 5'(l_q) - 5'd7;

  assign ev = {samp_q.x ^ samp_q.y, samp_q.x & samp_q.y, samp_q.y, samp_q.x};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      acc_sum[i] = {1'b0, acc_q[i]} + (ev[i] ? {1'b0, weight_q} : '0);
      carry[i]   = acc_sum[i][AW];
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      l_q     <= '0;
      stb_q   <= 1'b0;
      wrap_q  <= 1'b0;
      valid_q <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        acc_q[i] <= '0;
      end
    end else if (i_clear) begin
      l_q     <= (i_window_exp > L_MAX) ? L_MAX : i_window_exp;
      stb_q   <= 1'b0; // Drops the sample still in the weight stage.
      wrap_q  <= 1'b0;
      valid_q <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        acc_q[i] <= '0;
      end
    end else begin
      stb_q   <= i_strobe;
      wrap_q  <= i_strobe && i_wrap;
      valid_q <= wrap_q;
      if (stb_q) begin
        for (int i = 0; i < 4; i++) begin
          acc_q[i] <= wrap_q ? '0 : acc_sum[i][AW-1:0];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_strobe) begin
      samp_q   <= i_sample;
      weight_q <= AW'(1) << w_exp;
    end
    if (wrap_q) begin
      for (int i = 0; i < 4; i++) begin
        rep_q[i] <= scale(acc_sum[i][AW-1:0], shift);
      end
    end
  end

  assign o_report       = {rep_q[0], rep_q[1], rep_q[2], rep_q[3]};
  assign o_report_valid = valid_q;

  // CORR_ACC_W leaves room for a full window of the largest weights.
  a_acc_no_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    stb_q |-> (carry == '0));

endmodule

//--- hw/corr_count_rect.sv
`timescale 1ns/1ps
`include "corr_config.svh"

module corr_count_rect (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  corr_pkg::corr_sample_t i_sample,
  input  logic                   i_strobe,
  input  logic                   i_wrap,
  input  logic [3:0]             i_window_exp,
  input  logic                   i_clear,
  output corr_pkg::corr_report_t o_report,
  output logic                   o_report_valid
);

  localparam int         CW    = `CORR_MAX_WINDOW_EXP + 1; // A full window of ones fits.
  localparam logic [3:0] L_MAX = 4'(`CORR_MAX_WINDOW_EXP);

  logic [3:0]      l_q;
  logic [3:0]      ev;
  logic [CW-1:0]   cnt_q [4];
  logic [CW-1:0]   cnt_next [4];
  logic [3:0][7:0] rep_q;
  logic            valid_q;

  // Count times 256, shifted right by L, saturated to one byte.
  function automatic logic [7:0] scale(input logic [CW-1:0] cnt, input logic [3:0] l);
    logic [CW+7:0] full;
    full = {cnt, 8'd0} >> l;
    return (|full[CW+7:8]) ? 8'hff : full[7:0];
  endfunction

  // Bit order is x, y, intersection, symmetric difference from bit 0 up.
  assign ev = {i_sample.x ^ i_sample.y, i_sample.x & i_sample.y, i_sample.y, i_sample.x};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      cnt_next[i] = cnt_q[i] + CW'(ev[i]);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      l_q     <= '0;
      valid_q <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (i_clear) begin
      l_q     <= (i_window_exp > L_MAX) ? L_MAX : i_window_exp;
      valid_q <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      valid_q <= i_strobe && i_wrap;
      if (i_strobe) begin
        for (int i = 0; i < 4; i++) begin
          cnt_q[i] <= i_wrap ? '0 : cnt_next[i];
        end
      end
    end
  end

  // The last sample of the window is still in cnt_next here.
  always_ff @(posedge i_clk) begin
    if (i_strobe && i_wrap) begin
      for (int i = 0; i < 4; i++) begin
        rep_q[i] <= scale(cnt_next[i], l_q);
      end
    end
  end

  assign o_report       = {rep_q[0], rep_q[1], rep_q[2], rep_q[3]};
  assign o_report_valid = valid_q;

endmodule

//--- hw/corr_sample_timer.sv
`timescale 1ns/1ps
`include "corr_config.svh"

module corr_sample_timer (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  corr_pkg::corr_cfg_t             i_cfg,
  input  logic                            i_cfg_load,
  output logic                            o_strobe,
  output logic [`CORR_MAX_WINDOW_EXP-1:0] o_t,
  output logic                            o_wrap
);

  localparam int PW = `CORR_MAX_PERIOD_EXP;
  localparam int TW = `CORR_MAX_WINDOW_EXP;

  logic [3:0]    window_exp_q;
  logic [2:0]    period_exp_q;
  logic [PW-1:0] presc_q;
  logic [PW-1:0] period_m1;
  logic [TW-1:0] t_q;
  logic [TW-1:0] t_last;

  assign period_m1 = ~({PW{1'b1}} << period_exp_q);
  // Exponents above the maximum shift everything out and act as the maximum.
  assign t_last    = ~({TW{1'b1}} << window_exp_q);

  // A load cycle never samples, so every block downstream restarts cleanly.
  assign o_strobe = (presc_q == period_m1) && !i_cfg_load;
  assign o_wrap   = o_strobe && (t_q == t_last);
  assign o_t      = t_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      window_exp_q <= '0;
      period_exp_q <= '0;
    end else if (i_cfg_load) begin
      window_exp_q <= i_cfg.window_exp;
      period_exp_q <= i_cfg.period_exp;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      presc_q <= '0;
      t_q     <= '0;
    end else if (i_cfg_load) begin
      presc_q <= '0;
      t_q     <= '0;
    end else if (o_strobe) begin
      presc_q <= '0;
      t_q     <= o_wrap ? '0 : t_q + 1'b1;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  // The position never passes the last sample of the window.
  a_t_in_window: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_t <= t_last);

endmodule

//--- hw/corr_pkg.sv
package corr_pkg;

  typedef enum logic {
    SHAPE_RECT    = 1'b0,
    SHAPE_LOGDROP = 1'b1
  } corr_shape_e;

  // Taken as a whole on the load pulse.
  typedef struct packed {
    logic [3:0]  window_exp;
    corr_shape_e shape;
    logic [2:0]  period_exp;
  } corr_cfg_t;

  typedef struct packed {
    logic x;
    logic y;
  } corr_sample_t;

  // Fields are in packet order, after the window number.
  typedef struct packed {
    logic [7:0] cnt_x;
    logic [7:0] cnt_y;
    logic [7:0] cnt_isect;
    logic [7:0] cnt_symdiff;
  } corr_report_t;

  typedef logic [7:0] corr_byte_t;

endpackage

//--- hw/corr_config.svh
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// The largest window exponent. A window holds 2^L samples.
`define CORR_MAX_WINDOW_EXP 8

// Fractional bits of the logdrop weights, never below CORR_MAX_WINDOW_EXP.
`define CORR_PRECISION 8

`define CORR_MAX_PERIOD_EXP 7 // The sample period is 2^period_exp clocks.

`define CORR_FIFO_DEPTH 16 // Packet FIFO depth in bytes.

// Two spare bits above the largest weighted window sum.
`define CORR_ACC_W (`CORR_PRECISION + `CORR_MAX_WINDOW_EXP + 2)

`endif
